// ==== hw/issue_pkg.sv ====
package issue_pkg;

    // physical register space
    localparam int PREG_COUNT = 32;
    localparam int PREG_W     = $clog2(PREG_COUNT);

    typedef logic [PREG_W-1:0] preg_t;

    // datapath width
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    typedef enum logic [2:0] {
        ADD  = 3'd0,
        SUB  = 3'd1,
        AND  = 3'd2,
        OR   = 3'd3,
        XOR  = 3'd4,
        SLL  = 3'd5,
        SLT  = 3'd6,
        SLTU = 3'd7
    } alu_op_e;

    // renamed micro-op as it arrives from dispatch, 54 bits
    typedef struct packed {
        logic [2:0] spare;
        alu_op_e    op;
        preg_t      src1;
        preg_t      src2;
        preg_t      dst;
        logic       use_imm;
        // already sign-extended by the decoder
        word_t      imm;
    } alu_uop_t;

    // result leaving the ALU, 37 bits
    typedef struct packed {
        preg_t dst;
        word_t data;
    } wb_t;

endpackage

// ==== hw/busy_table.sv ====
module busy_table import issue_pkg::*; #(
    parameter int IQ_DEPTH = 8
) (
    input  logic                 aclk,
    input  logic                 reset_i,
    input  logic                 flush_i,
    input  logic                 set_valid_i,
    input  preg_t                set_num_i,
    input  logic                 clear_valid_i,
    input  preg_t                clear_num_i,
    input  preg_t [IQ_DEPTH-1:0] src1_num_i,
    input  preg_t [IQ_DEPTH-1:0] src2_num_i,
    output logic  [IQ_DEPTH-1:0] src1_busy_o,
    output logic  [IQ_DEPTH-1:0] src2_busy_o
);

    // one bit per physical register that is high while its producer waits in the queue
    logic [PREG_COUNT-1:0] busy;

    always_ff @(posedge aclk) begin
        if (reset_i || flush_i) begin
            busy <= '0;
        end else begin
            // a register is never set and cleared in the same cycle
            // because its producer cannot issue in the cycle it is dispatched
            if (set_valid_i) begin
                busy[set_num_i] <= 1'b1;
            end
            if (clear_valid_i) begin
                busy[clear_num_i] <= 1'b0;
            end
        end
    end

    // parallel lookup for every queue slot
    // the register woken up by the issue register already reads as free
    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            src1_busy_o[i] = busy[src1_num_i[i]]
                             && !(clear_valid_i && clear_num_i == src1_num_i[i]);
            src2_busy_o[i] = busy[src2_num_i[i]]
                             && !(clear_valid_i && clear_num_i == src2_num_i[i]);
        end
    end

endmodule

// ==== hw/issue_queue.sv ====
module issue_queue import issue_pkg::*; #(
    parameter int IQ_DEPTH = 8
) (
    input  logic                 aclk,
    input  logic                 reset_i,
    input  logic                 flush_i,
    input  logic                 issue_stall_i,
    input  logic                 dispatch_valid_i,
    input  alu_uop_t             dispatch_uop_i,
    output logic                 dispatch_ready_o,
    output preg_t [IQ_DEPTH-1:0] src1_num_o,
    output preg_t [IQ_DEPTH-1:0] src2_num_o,
    input  logic  [IQ_DEPTH-1:0] src1_busy_i,
    input  logic  [IQ_DEPTH-1:0] src2_busy_i,
    output logic                 issue_valid_o,
    output alu_uop_t             issue_uop_o
);

    localparam int IDX_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;

    alu_uop_t            slot_uop [IQ_DEPTH];
    logic [IQ_DEPTH-1:0] slot_valid;
    logic [IQ_DEPTH-1:0] slot_ready;

    logic [IDX_W-1:0]    free_idx;
    logic [IDX_W-1:0]    sel_idx;
    logic                sel_found;
    logic                enq;
    logic                deq;

    // scoreboard lookup and per-slot readiness
    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            src1_num_o[i] = slot_uop[i].src1;
            src2_num_o[i] = slot_uop[i].src2;
            // src2 does not matter when the immediate replaces it
            slot_ready[i] = slot_valid[i] && !src1_busy_i[i]
                            && (slot_uop[i].use_imm || !src2_busy_i[i]);
        end
    end

    // lowest free slot for enqueue, lowest ready slot for issue;
    // scanning downwards leaves the lowest index in place
    always_comb begin
        free_idx = '0;
        sel_idx  = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                free_idx = IDX_W'(i);
            end
            if (slot_ready[i]) begin
                sel_idx = IDX_W'(i);
            end
        end
    end

    assign sel_found        = |slot_ready;
    assign dispatch_ready_o = !(&slot_valid);

    assign enq = dispatch_valid_i && dispatch_ready_o;
    assign deq = sel_found && !issue_stall_i;

    always_ff @(posedge aclk) begin
        if (reset_i || flush_i) begin
            slot_valid <= '0;
        end else begin
            // enqueue targets a free slot, so it never meets the issued one
            if (deq) begin
                slot_valid[sel_idx] <= 1'b0;
            end
            if (enq) begin
                slot_valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (enq) begin
            slot_uop[free_idx] <= dispatch_uop_i;
        end
    end

    // issue register, its valid also drives the wakeup in the busy table
    always_ff @(posedge aclk) begin
        if (reset_i || flush_i) begin
            issue_valid_o <= 1'b0;
        end else begin
            issue_valid_o <= deq;
        end
    end

    always_ff @(posedge aclk) begin
        if (deq) begin
            issue_uop_o <= slot_uop[sel_idx];
        end
    end

endmodule

// ==== hw/phys_regfile.sv ====
module phys_regfile import issue_pkg::*; (
    input  logic     aclk,
    input  logic     reset_i,
    input  logic     flush_i,
    input  logic     issue_valid_i,
    input  alu_uop_t issue_uop_i,
    input  logic     wb_valid_i,
    input  wb_t      wb_i,
    output logic     read_valid_o,
    output alu_uop_t read_uop_o,
    output word_t    read_data1_o,
    output word_t    read_data2_o
);

    word_t regs [PREG_COUNT];
    word_t rd_data1;
    word_t rd_data2;

    // unwritten registers must read zero, so the array is cleared on reset
    always_ff @(posedge aclk) begin
        if (reset_i) begin
            for (int i = 0; i < PREG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid_i) begin
            regs[wb_i.dst] <= wb_i.data;
        end
    end

    // write-first: a same-cycle write to the read register wins
    always_comb begin
        rd_data1 = regs[issue_uop_i.src1];
        rd_data2 = regs[issue_uop_i.src2];
        if (wb_valid_i && wb_i.dst == issue_uop_i.src1) begin
            rd_data1 = wb_i.data;
        end
        if (wb_valid_i && wb_i.dst == issue_uop_i.src2) begin
            rd_data2 = wb_i.data;
        end
    end

    // read stage register
    always_ff @(posedge aclk) begin
        if (reset_i || flush_i) begin
            read_valid_o <= 1'b0;
        end else begin
            read_valid_o <= issue_valid_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (issue_valid_i) begin
            read_uop_o   <= issue_uop_i;
            read_data1_o <= rd_data1;
            read_data2_o <= rd_data2;
        end
    end

endmodule

// ==== hw/int_alu.sv ====
module int_alu import issue_pkg::*; (
    input  logic     aclk,
    input  logic     reset_i,
    input  logic     flush_i,
    input  logic     read_valid_i,
    input  alu_uop_t read_uop_i,
    input  word_t    read_data1_i,
    input  word_t    read_data2_i,
    output logic     wb_valid_o,
    output wb_t      wb_o
);

    word_t op_a;
    word_t op_b;
    word_t result;

    // operand select
    // the read stage misses a producer that is still in the writeback register
    always_comb begin
        op_a = read_data1_i;
        if (wb_valid_o && wb_o.dst == read_uop_i.src1) begin
            op_a = wb_o.data;
        end
        if (read_uop_i.use_imm) begin
            op_b = read_uop_i.imm;
        end else if (wb_valid_o && wb_o.dst == read_uop_i.src2) begin
            op_b = wb_o.data;
        end else begin
            op_b = read_data2_i;
        end
    end

    always_comb begin
        case (read_uop_i.op)
            ADD:     result = op_a + op_b;
            SUB:     result = op_a - op_b;
            AND:     result = op_a & op_b;
            OR:      result = op_a | op_b;
            XOR:     result = op_a ^ op_b;
            // shift amount is the low 5 bits only
            SLL:     result = op_a << op_b[4:0];
            SLT:     result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLTU:    result = {{(XLEN-1){1'b0}}, op_a < op_b};
            default: result = '0;
        endcase
    end

    // writeback register, also the bypass source
    always_ff @(posedge aclk) begin
        if (reset_i || flush_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= read_valid_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (read_valid_i) begin
            wb_o.dst  <= read_uop_i.dst;
            wb_o.data <= result;
        end
    end

endmodule

// ==== hw/alu_issue_path.sv ====
module alu_issue_path import issue_pkg::*; #(
    parameter int IQ_DEPTH = 8
) (
    input  logic     aclk,
    input  logic     reset_i,
    input  logic     dispatch_valid_i,
    input  alu_uop_t dispatch_uop_i,
    output logic     dispatch_ready_o,
    input  logic     issue_stall_i,
    input  logic     flush_i,
    output logic     wb_valid_o,
    output wb_t      wb_o
);

    // queue to scoreboard lookup
    preg_t [IQ_DEPTH-1:0] src1_num;
    preg_t [IQ_DEPTH-1:0] src2_num;
    logic  [IQ_DEPTH-1:0] src1_busy;
    logic  [IQ_DEPTH-1:0] src2_busy;

    logic     issue_valid;
    alu_uop_t issue_uop;

    logic     read_valid;
    alu_uop_t read_uop;
    word_t    read_data1;
    word_t    read_data2;

    logic     wb_valid;
    wb_t      wb;

    busy_table #(
        .IQ_DEPTH (IQ_DEPTH)
    ) u_busy_table (
        .aclk          (aclk),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .set_valid_i   (dispatch_valid_i && dispatch_ready_o),
        .set_num_i     (dispatch_uop_i.dst),
        // wakeup happens as the micro-op enters the issue register
        .clear_valid_i (issue_valid),
        .clear_num_i   (issue_uop.dst),
        .src1_num_i    (src1_num),
        .src2_num_i    (src2_num),
        .src1_busy_o   (src1_busy),
        .src2_busy_o   (src2_busy)
    );

    issue_queue #(
        .IQ_DEPTH (IQ_DEPTH)
    ) u_issue_queue (
        .aclk             (aclk),
        .reset_i          (reset_i),
        .flush_i          (flush_i),
        .issue_stall_i    (issue_stall_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_uop_i   (dispatch_uop_i),
        .dispatch_ready_o (dispatch_ready_o),
        .src1_num_o       (src1_num),
        .src2_num_o       (src2_num),
        .src1_busy_i      (src1_busy),
        .src2_busy_i      (src2_busy),
        .issue_valid_o    (issue_valid),
        .issue_uop_o      (issue_uop)
    );

    phys_regfile u_phys_regfile (
        .aclk          (aclk),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid),
        .issue_uop_i   (issue_uop),
        .wb_valid_i    (wb_valid),
        .wb_i          (wb),
        .read_valid_o  (read_valid),
        .read_uop_o    (read_uop),
        .read_data1_o  (read_data1),
        .read_data2_o  (read_data2)
    );

    int_alu u_int_alu (
        .aclk         (aclk),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .read_valid_i (read_valid),
        .read_uop_i   (read_uop),
        .read_data1_i (read_data1),
        .read_data2_i (read_data2),
        .wb_valid_o   (wb_valid),
        .wb_o         (wb)
    );

    assign wb_valid_o = wb_valid;
    assign wb_o       = wb;

endmodule

// ==== sim/tb_alu_issue_path.sv ====
module tb_alu_issue_path import issue_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    IQ_DEPTH    = 8;
    localparam int    MAX_CASES   = 40;
    localparam int    FIELDS      = 8;
    localparam int    DRAIN_LIMIT = 64;
    localparam string CASE_FILE   = "sim/alu_issue_cases.txt";

    logic     aclk;
    logic     reset_i;
    logic     dispatch_valid_i;
    alu_uop_t dispatch_uop_i;
    logic     dispatch_ready_o;
    logic     issue_stall_i;
    logic     flush_i;
    logic     wb_valid_o;
    wb_t      wb_o;

    // eight words per case line
    logic [31:0]           case_mem [MAX_CASES*FIELDS];
    int                    num_cases;
    word_t                 exp_data [PREG_COUNT];
    // one bit per dst whose writeback is still owed
    logic [PREG_COUNT-1:0] pending;
    int                    wb_seen = 0;
    int                    value_errors = 0;
    int                    protocol_errors = 0;
    int                    cycles = 0;
    int                    cycle_limit = 200;
    int                    seed;

    alu_issue_path #(
        .IQ_DEPTH (IQ_DEPTH)
    ) UUT (
        .aclk             (aclk),
        .reset_i          (reset_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_uop_i   (dispatch_uop_i),
        .dispatch_ready_o (dispatch_ready_o),
        .issue_stall_i    (issue_stall_i),
        .flush_i          (flush_i),
        .wb_valid_o       (wb_valid_o),
        .wb_o             (wb_o)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, writebacks owed for %h", cycles, pending);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_wb(input wb_t got);
        if (!pending[got.dst]) begin
            $display("unexpected or duplicate writeback to register %0d at %0t", got.dst, $time);
            protocol_errors++;
        end else begin
            if (got.data !== exp_data[got.dst]) begin
                $display("FAIL wb_o.data (dst %h): got %h, expected %h",
                         got.dst, got.data, exp_data[got.dst]);
                value_errors++;
            end
            pending[got.dst] = 1'b0;
        end
        wb_seen++;
    endtask

    task automatic check_ready(input logic expected);
        if (dispatch_ready_o !== expected) begin
            $display("FAIL dispatch_ready_o: got %h, expected %h", dispatch_ready_o, expected);
            value_errors++;
        end
    endtask

    // outputs settle right after the edge, inputs change 1 ns after it
    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge aclk);
            #1;
            if (!reset_i && wb_valid_o) begin
                check_wb(wb_o);
            end
        end
    endtask

    function automatic alu_uop_t case_uop(input int idx);
        alu_uop_t uop;
        int       base;
        base         = idx * FIELDS;
        uop          = '0;
        uop.op       = alu_op_e'(case_mem[base+1][2:0]);
        uop.src1     = preg_t'(case_mem[base+2]);
        uop.src2     = preg_t'(case_mem[base+3]);
        uop.dst      = preg_t'(case_mem[base+4]);
        uop.use_imm  = case_mem[base+5][0];
        uop.imm      = case_mem[base+6];
        return uop;
    endfunction

    // holds the micro-op until the queue takes it
    task automatic dispatch_case(input int idx);
        alu_uop_t uop;
        uop              = case_uop(idx);
        dispatch_valid_i = 1'b1;
        dispatch_uop_i   = uop;
        while (dispatch_ready_o !== 1'b1) begin
            step_cycles(1);
        end
        exp_data[uop.dst] = case_mem[idx*FIELDS+7];
        pending[uop.dst]  = 1'b1;
        step_cycles(1);
        dispatch_valid_i = 1'b0;
    endtask

    task automatic drain_all();
        int waited;
        waited = 0;
        while (pending != '0 && waited < DRAIN_LIMIT) begin
            step_cycles(1);
            waited++;
        end
        if (pending != '0) begin
            $display("missing writeback for registers %h", pending);
            protocol_errors++;
            pending = '0;
        end
        // a late duplicate would show up here
        step_cycles(3);
    endtask

    task automatic dispatch_phase(input int phase, input bit gaps);
        for (int i = 0; i < num_cases; i++) begin
            if (case_mem[i*FIELDS] == phase) begin
                dispatch_case(i);
                if (gaps) begin
                    step_cycles($unsigned($random(seed)) % 3);
                end
            end
        end
    endtask

    task automatic stalled_phase(input int phase);
        int accepted;
        int wb_before;
        accepted      = 0;
        wb_before     = wb_seen;
        issue_stall_i = 1'b1;
        for (int i = 0; i < num_cases; i++) begin
            if (case_mem[i*FIELDS] == phase) begin
                if (accepted == IQ_DEPTH) begin
                    // queue full, nothing may leave while stalled
                    check_ready(1'b0);
                    step_cycles(4);
                    if (wb_seen != wb_before) begin
                        $display("writeback appeared while issue was stalled");
                        protocol_errors++;
                    end
                    issue_stall_i = 1'b0;
                end else if (issue_stall_i) begin
                    check_ready(1'b1);
                end
                dispatch_case(i);
                accepted++;
            end
        end
        issue_stall_i = 1'b0;
    endtask

    task automatic flushed_phase(input int phase);
        issue_stall_i = 1'b1;
        dispatch_phase(phase, 1'b0);
        step_cycles(2);
        flush_i = 1'b1;
        step_cycles(1);
        flush_i       = 1'b0;
        issue_stall_i = 1'b0;
        // flushed micro-ops never write back
        pending = '0;
        check_ready(1'b1);
        step_cycles(8);
    endtask

    initial begin
        reset_i          = 1'b1;
        dispatch_valid_i = 1'b0;
        dispatch_uop_i   = '0;
        issue_stall_i    = 1'b0;
        flush_i          = 1'b0;
        pending          = '0;
        seed             = 92;

        $readmemh(CASE_FILE, case_mem);
        num_cases = 0;
        while (num_cases < MAX_CASES && case_mem[num_cases*FIELDS] != 32'hf) begin
            num_cases++;
        end
        cycle_limit = 20 * num_cases + 200;
        if (num_cases == 0) begin
            $display("case file holds no usable lines");
            protocol_errors++;
        end

        step_cycles(10);
        reset_i = 1'b0;
        step_cycles(1);
        check_ready(1'b1);
        step_cycles(4);

        dispatch_phase(0, 1'b1);
        // dependents follow each other without gaps
        dispatch_phase(1, 1'b0);
        drain_all();
        stalled_phase(2);
        drain_all();
        flushed_phase(3);
        dispatch_phase(4, 1'b1);
        drain_all();

        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== sim/alu_issue_cases.txt ====
// phase op src1 src2 dst use_imm imm expected, all hex
// phase 3 lines get flushed so their expected column is unused, phase f ends the list
0 0 00 00 01 1 00000123 00000123
0 1 00 00 02 1 00000010 fffffff0
0 2 00 00 03 1 ffffffff 00000000
0 3 00 00 04 1 80000001 80000001
0 4 00 00 05 1 0000f0f0 0000f0f0
0 5 00 00 06 1 00000004 00000000
0 6 00 00 07 1 ffffffff 00000000
0 7 00 00 08 1 ffffffff 00000001
1 0 01 02 09 0 00000000 00000113
1 1 09 01 0a 0 00000000 fffffff0
1 4 0a 05 0b 0 00000000 ffff0f00
1 5 05 08 0c 0 00000000 0001e1e0
1 6 0a 09 0d 0 00000000 00000001
1 7 0a 09 0e 0 00000000 00000000
1 2 0b 00 0f 1 0000ffff 00000f00
1 3 0f 0c 10 0 00000000 0001efe0
1 5 04 00 11 1 00000024 00000010
2 0 10 00 12 1 00000020 0001f000
2 1 12 0c 13 0 00000000 00000e20
2 4 13 00 14 1 0000ffff 0000f1df
2 3 00 00 15 1 00000007 00000007
2 5 15 08 16 0 00000000 0000000e
2 7 15 16 17 0 00000000 00000001
2 6 02 00 18 1 fffffff1 00000001
2 2 0b 14 19 0 00000000 00000100
2 0 19 18 1a 0 00000000 00000101
3 0 00 00 1b 1 00000055 00000000
3 0 1b 00 1c 1 00000001 00000000
3 3 1a 00 1d 1 00000000 00000000
4 0 1b 00 1e 1 00000009 00000009
4 1 1a 1c 1f 0 00000000 00000101
f 0 00 00 00 0 00000000 00000000

// ==== vlog.f ====
hw/issue_pkg.sv
hw/busy_table.sv
hw/issue_queue.sv
hw/phys_regfile.sv
hw/int_alu.sv
hw/alu_issue_path.sv
sim/tb_alu_issue_path.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
    --top-module tb_alu_issue_path -o tb_alu_issue_path
./obj_dir/tb_alu_issue_path | tee sim.log

if grep -q "^Done: no errors$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
